// File: src/swu_pkg.sv
`default_nettype none

package swu_pkg;

   // default geometry, the top level overrides these
   localparam int DEF_SIMD         = 2;
   localparam int DEF_IP_PRECISION = 4;
   localparam int DEF_IFM_CHANNELS = 4;
   localparam int DEF_IFM_DIM      = 6;
   localparam int DEF_KERNEL_DIM   = 3;
   localparam int DEF_STRIDE       = 1;

   // kernel rows plus one stride of look-ahead for the writer
   localparam int DEF_BUFFER_SIZE =
      (DEF_KERNEL_DIM + DEF_STRIDE) * DEF_IFM_DIM * (DEF_IFM_CHANNELS / DEF_SIMD);

   // number of stream words in one input frame
   function automatic int frame_words(input int ifm_dim, input int eff_channels);
      return ifm_dim * ifm_dim * eff_channels;
   endfunction

endpackage

`default_nettype wire

// File: src/swu_buffer_ram.sv
`default_nettype none

module swu_buffer_ram #(
   parameter int SIMD         = swu_pkg::DEF_SIMD,
   parameter int IP_PRECISION = swu_pkg::DEF_IP_PRECISION,
   parameter int BUFFER_SIZE  = swu_pkg::DEF_BUFFER_SIZE,
   localparam int DW = SIMD * IP_PRECISION,
   localparam int AW = $clog2(BUFFER_SIZE)
) (
   input  wire logic          clk,
   input  wire logic          wr_en_i,
   input  wire logic [AW-1:0] wr_addr_i,
   input  wire logic [DW-1:0] wr_data_i,
   input  wire logic          rd_en_i,
   input  wire logic [AW-1:0] rd_addr_i,
   output      logic [DW-1:0] rd_data_o
);

   logic [DW-1:0] mem [BUFFER_SIZE];
   logic [DW-1:0] rd_q;

   // write port, one word per accepted input beat
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // registered read port
   // the register keeps its word while rd_en_i is low so a stalled
   // output stage can still pick it up later
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_q <= mem[rd_addr_i];
      end
   end

   assign rd_data_o = rd_q;

endmodule

`default_nettype wire

// File: src/swu_write_ctrl.sv
`default_nettype none

module swu_write_ctrl #(
   parameter int SIMD         = swu_pkg::DEF_SIMD,
   parameter int IFM_CHANNELS = swu_pkg::DEF_IFM_CHANNELS,
   parameter int IFM_DIM      = swu_pkg::DEF_IFM_DIM,
   parameter int BUFFER_SIZE  = swu_pkg::DEF_BUFFER_SIZE,
   localparam int EFF_CHANNELS = IFM_CHANNELS / SIMD,
   localparam int FRAME_WORDS  = swu_pkg::frame_words(IFM_DIM, EFF_CHANNELS),
   localparam int CNT_W        = $clog2(FRAME_WORDS + 1),
   localparam int AW           = $clog2(BUFFER_SIZE)
) (
   input  wire logic             clk,
   input  wire logic             resetn,
   input  wire logic             in_valid_i,
   output      logic             in_ready_o,
   input  wire logic [CNT_W-1:0] rd_base_i,
   input  wire logic             frame_done_i,
   output      logic             wr_en_o,
   output      logic [AW-1:0]    wr_addr_o,
   output      logic [CNT_W-1:0] wr_count_o
);

   localparam int LIM_W = $clog2(FRAME_WORDS + BUFFER_SIZE + 1);

   logic [AW-1:0]    wr_addr;
   logic [CNT_W-1:0] wr_count;
   logic [LIM_W-1:0] wr_limit;

   // first word index the writer may not touch yet
   assign wr_limit = LIM_W'(rd_base_i) + LIM_W'(BUFFER_SIZE);

   // stop at the end of the frame and when the buffer holds only live words
   assign in_ready_o = (wr_count < CNT_W'(FRAME_WORDS)) &&
                       (LIM_W'(wr_count) < wr_limit);
   assign wr_en_o    = in_valid_i && in_ready_o;
   assign wr_addr_o  = wr_addr;
   assign wr_count_o = wr_count;

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         wr_addr  <= '0;
         wr_count <= '0;
      end else if (wr_en_o) begin
         wr_count <= wr_count + 1'b1;
         if (wr_addr == AW'(BUFFER_SIZE - 1)) begin
            wr_addr <= '0;
         end else begin
            wr_addr <= wr_addr + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // checks

   // the writer never laps the oldest word the window still needs
   a_no_overrun: assert property (@(posedge clk) disable iff (!resetn)
      LIM_W'(wr_count) <= wr_limit);

endmodule

`default_nettype wire

// File: src/swu_window_ctrl.sv
`default_nettype none

module swu_window_ctrl #(
   parameter int SIMD         = swu_pkg::DEF_SIMD,
   parameter int IFM_CHANNELS = swu_pkg::DEF_IFM_CHANNELS,
   parameter int IFM_DIM      = swu_pkg::DEF_IFM_DIM,
   parameter int KERNEL_DIM   = swu_pkg::DEF_KERNEL_DIM,
   parameter int STRIDE       = swu_pkg::DEF_STRIDE,
   parameter int BUFFER_SIZE  = swu_pkg::DEF_BUFFER_SIZE,
   localparam int EFF_CHANNELS = IFM_CHANNELS / SIMD,
   localparam int FRAME_WORDS  = swu_pkg::frame_words(IFM_DIM, EFF_CHANNELS),
   localparam int CNT_W        = $clog2(FRAME_WORDS + 1),
   localparam int AW           = $clog2(BUFFER_SIZE)
) (
   input  wire logic             clk,
   input  wire logic             resetn,
   input  wire logic [CNT_W-1:0] wr_count_i,
   input  wire logic             rd_allow_i,
   input  wire logic             frame_done_i,
   output      logic             rd_issue_o,
   output      logic [AW-1:0]    rd_addr_o,
   output      logic             rd_last_o,
   output      logic [CNT_W-1:0] rd_base_o
);

   localparam int OUT_DIM  = (IFM_DIM - KERNEL_DIM) / STRIDE + 1;
   localparam int CH_W     = (EFF_CHANNELS > 1) ? $clog2(EFF_CHANNELS) : 1;
   localparam int K_W      = (KERNEL_DIM > 1) ? $clog2(KERNEL_DIM) : 1;
   localparam int O_W      = (OUT_DIM > 1) ? $clog2(OUT_DIM) : 1;
   localparam int ROW_STEP = STRIDE * IFM_DIM * EFF_CHANNELS;

   ////////////////////////////////////////////////////////////
   // window loop state

   logic [CH_W-1:0]  ch;
   logic [K_W-1:0]   kw;
   logic [K_W-1:0]   kh;
   logic [O_W-1:0]   ocol;
   logic [O_W-1:0]   orow;
   logic             done;

   // absolute index and buffer address of the current output row start
   logic [CNT_W-1:0] rd_base;
   logic [AW-1:0]    row_base;

   logic             ch_end;
   logic             kw_end;
   logic             kh_end;
   logic             col_end;
   logic             row_end;
   logic             win_end;
   logic [AW-1:0]    win_ofs;
   logic [CNT_W-1:0] win_idx;
   logic [AW:0]      addr_sum;
   logic [AW:0]      row_sum;
   logic [AW-1:0]    row_base_nxt;

   assign ch_end  = (ch == CH_W'(EFF_CHANNELS - 1));
   assign kw_end  = (kw == K_W'(KERNEL_DIM - 1));
   assign kh_end  = (kh == K_W'(KERNEL_DIM - 1));
   assign col_end = (ocol == O_W'(OUT_DIM - 1));
   assign row_end = (orow == O_W'(OUT_DIM - 1));
   assign win_end = ch_end && kw_end && kh_end;

   // word offset inside the rows of the current output row
   assign win_ofs = AW'((kh * IFM_DIM + ocol * STRIDE + kw) * EFF_CHANNELS + ch);
   assign win_idx = rd_base + CNT_W'(win_ofs);

   // at most one wrap since row_base and win_ofs are both below BUFFER_SIZE
   assign addr_sum  = {1'b0, row_base} + {1'b0, win_ofs};
   assign rd_addr_o = (addr_sum >= (AW+1)'(BUFFER_SIZE)) ?
                      AW'(addr_sum - (AW+1)'(BUFFER_SIZE)) : addr_sum[AW-1:0];

   assign row_sum      = {1'b0, row_base} + (AW+1)'(ROW_STEP);
   assign row_base_nxt = (row_sum >= (AW+1)'(BUFFER_SIZE)) ?
                         AW'(row_sum - (AW+1)'(BUFFER_SIZE)) : row_sum[AW-1:0];

   ////////////////////////////////////////////////////////////
   // issue rule

   // only read words the writer has already stored
   assign rd_issue_o = !done && rd_allow_i && (win_idx < wr_count_i);
   assign rd_last_o  = win_end && col_end && row_end;
   assign rd_base_o  = rd_base;

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         ch       <= '0;
         kw       <= '0;
         kh       <= '0;
         ocol     <= '0;
         orow     <= '0;
         done     <= 1'b0;
         rd_base  <= '0;
         row_base <= '0;
      end else if (rd_issue_o) begin
         if (rd_last_o) begin
            // hold here until the last word has left the unit
            done <= 1'b1;
         end else if (!ch_end) begin
            ch <= ch + 1'b1;
         end else begin
            ch <= '0;
            if (!kw_end) begin
               kw <= kw + 1'b1;
            end else begin
               kw <= '0;
               if (!kh_end) begin
                  kh <= kh + 1'b1;
               end else begin
                  kh <= '0;
                  if (!col_end) begin
                     ocol <= ocol + 1'b1;
                  end else begin
                     // row complete, release STRIDE input rows to the writer
                     ocol     <= '0;
                     orow     <= orow + 1'b1;
                     rd_base  <= rd_base + CNT_W'(ROW_STEP);
                     row_base <= row_base_nxt;
                  end
               end
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // checks

   // an issued word is written and has not been overwritten by the writer
   a_read_valid: assert property (@(posedge clk) disable iff (!resetn)
      rd_issue_o |-> (win_idx < wr_count_i) &&
                     (int'(wr_count_i) <= int'(win_idx) + BUFFER_SIZE));

endmodule

`default_nettype wire

// File: src/swu_output_stage.sv
`default_nettype none

module swu_output_stage #(
   parameter int SIMD         = swu_pkg::DEF_SIMD,
   parameter int IP_PRECISION = swu_pkg::DEF_IP_PRECISION,
   localparam int DW = SIMD * IP_PRECISION
) (
   input  wire logic          clk,
   input  wire logic          resetn,
   input  wire logic          rd_issue_i,
   input  wire logic          rd_last_i,
   input  wire logic [DW-1:0] ram_data_i,
   output      logic          rd_allow_o,
   output      logic          ram_rd_en_o,
   output      logic [DW-1:0] out_data_o,
   output      logic          out_valid_o,
   input  wire logic          out_ready_i,
   output      logic          frame_done_o
);

   // r_* tracks the RAM read register, q_* the output register
   logic          r_valid;
   logic          r_last;
   logic          q_valid;
   logic          q_last;
   logic          q_advance;
   logic [DW-1:0] q_data;
   logic          frame_done;

   assign q_advance   = out_ready_i || !q_valid;
   assign rd_allow_o  = !r_valid || q_advance;
   // load the RAM register only into a free slot
   assign ram_rd_en_o = rd_issue_i && rd_allow_o;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         r_valid    <= 1'b0;
         r_last     <= 1'b0;
         q_valid    <= 1'b0;
         q_last     <= 1'b0;
         frame_done <= 1'b0;
      end else begin
         if (rd_allow_o) begin
            r_valid <= rd_issue_i;
            r_last  <= rd_issue_i && rd_last_i;
         end
         if (q_advance) begin
            q_valid <= r_valid;
            q_last  <= r_last;
         end
         // one cycle after the last word of the frame is taken
         frame_done <= q_valid && q_last && out_ready_i;
      end
   end

   always_ff @(posedge clk) begin
      if (q_advance && r_valid) begin
         q_data <= ram_data_i;
      end
   end

   assign out_data_o   = q_data;
   assign out_valid_o  = q_valid;
   assign frame_done_o = frame_done;

   // a stalled word stays on the bus until it is taken
   a_hold_stable: assert property (@(posedge clk) disable iff (!resetn)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

`default_nettype wire

// File: src/swu_top.sv
`default_nettype none

module swu_top #(
   parameter int SIMD         = swu_pkg::DEF_SIMD,
   parameter int IP_PRECISION = swu_pkg::DEF_IP_PRECISION,
   parameter int IFM_CHANNELS = swu_pkg::DEF_IFM_CHANNELS,
   parameter int IFM_DIM      = swu_pkg::DEF_IFM_DIM,
   parameter int KERNEL_DIM   = swu_pkg::DEF_KERNEL_DIM,
   parameter int STRIDE       = swu_pkg::DEF_STRIDE,
   parameter int BUFFER_SIZE  = swu_pkg::DEF_BUFFER_SIZE
) (
   input  wire logic                         clk,
   input  wire logic                         resetn,
   input  wire logic [SIMD*IP_PRECISION-1:0] in_data_i,
   input  wire logic                         in_valid_i,
   output      logic                         in_ready_o,
   output      logic [SIMD*IP_PRECISION-1:0] out_data_o,
   output      logic                         out_valid_o,
   input  wire logic                         out_ready_i
);

   localparam int EFF_CHANNELS = IFM_CHANNELS / SIMD;
   localparam int FRAME_WORDS  = swu_pkg::frame_words(IFM_DIM, EFF_CHANNELS);
   localparam int CNT_W        = $clog2(FRAME_WORDS + 1);
   localparam int AW           = $clog2(BUFFER_SIZE);
   localparam int DW           = SIMD * IP_PRECISION;

   logic             wr_en;
   logic [AW-1:0]    wr_addr;
   logic [CNT_W-1:0] wr_count;
   logic [CNT_W-1:0] rd_base;
   logic             rd_issue;
   logic [AW-1:0]    rd_addr;
   logic             rd_last;
   logic             rd_allow;
   logic             ram_rd_en;
   logic [DW-1:0]    ram_data;
   logic             frame_done;

   swu_write_ctrl #(
      .SIMD         (SIMD),
      .IFM_CHANNELS (IFM_CHANNELS),
      .IFM_DIM      (IFM_DIM),
      .BUFFER_SIZE  (BUFFER_SIZE)
   ) u_write_ctrl (
      .clk          (clk),
      .resetn       (resetn),
      .in_valid_i   (in_valid_i),
      .in_ready_o   (in_ready_o),
      .rd_base_i    (rd_base),
      .frame_done_i (frame_done),
      .wr_en_o      (wr_en),
      .wr_addr_o    (wr_addr),
      .wr_count_o   (wr_count)
   );

   swu_window_ctrl #(
      .SIMD         (SIMD),
      .IFM_CHANNELS (IFM_CHANNELS),
      .IFM_DIM      (IFM_DIM),
      .KERNEL_DIM   (KERNEL_DIM),
      .STRIDE       (STRIDE),
      .BUFFER_SIZE  (BUFFER_SIZE)
   ) u_window_ctrl (
      .clk          (clk),
      .resetn       (resetn),
      .wr_count_i   (wr_count),
      .rd_allow_i   (rd_allow),
      .frame_done_i (frame_done),
      .rd_issue_o   (rd_issue),
      .rd_addr_o    (rd_addr),
      .rd_last_o    (rd_last),
      .rd_base_o    (rd_base)
   );

   swu_buffer_ram #(
      .SIMD         (SIMD),
      .IP_PRECISION (IP_PRECISION),
      .BUFFER_SIZE  (BUFFER_SIZE)
   ) u_buffer_ram (
      .clk          (clk),
      .wr_en_i      (wr_en),
      .wr_addr_i    (wr_addr),
      .wr_data_i    (in_data_i),
      .rd_en_i      (ram_rd_en),
      .rd_addr_i    (rd_addr),
      .rd_data_o    (ram_data)
   );

   swu_output_stage #(
      .SIMD         (SIMD),
      .IP_PRECISION (IP_PRECISION)
   ) u_output_stage (
      .clk          (clk),
      .resetn       (resetn),
      .rd_issue_i   (rd_issue),
      .rd_last_i    (rd_last),
      .ram_data_i   (ram_data),
      .rd_allow_o   (rd_allow),
      .ram_rd_en_o  (ram_rd_en),
      .out_data_o   (out_data_o),
      .out_valid_o  (out_valid_o),
      .out_ready_i  (out_ready_i),
      .frame_done_o (frame_done)
   );

endmodule

`default_nettype wire

// File: dv/swu_tb_tasks.svh
`ifndef SWU_TB_TASKS_SVH
`define SWU_TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
   check_count++;
   if (actual !== expected) begin
      $display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
      error_count++;
   end
endtask

task automatic report_timeout(input string what);
   $display("%0d ns: timeout, %s", $time, what);
   error_count++;
endtask

task automatic report_test(input string name, input int errors_before);
   if (error_count == errors_before) begin
      $display("test %s: ok", name);
   end else begin
      $display("test %s: %0d errors", name, error_count - errors_before);
   end
endtask

// ends on a falling edge with reset released
task automatic apply_reset();
   resetn      = 1'b0;
   in_valid_i  = 1'b0;
   in_data_i   = '0;
   out_ready_i = 1'b0;
   repeat (5) @(posedge clk);
   @(negedge clk);
   resetn = 1'b1;
endtask

task automatic drive_frame(input int f, input int gap_pct);
   int wait_cycles;
   for (int i = 0; i < FRAME_WORDS; i++) begin
      while (gap_pct > 0 && (next_random() % 100) < gap_pct) begin
         in_valid_i = 1'b0;
         @(negedge clk);
      end
      in_valid_i  = 1'b1;
      in_data_i   = frame_data[f][i];
      wait_cycles = 0;
      // ready only moves after a rising edge, so it is settled here
      while (!in_ready_o) begin
         if (wait_cycles == TIMEOUT) begin
            report_timeout("in_ready_o stayed low, an input word was never accepted");
            in_valid_i = 1'b0;
            return;
         end
         wait_cycles++;
         @(negedge clk);
      end
      @(negedge clk);
   end
   in_valid_i = 1'b0;
endtask

task automatic collect_frame(input int f, input int stall_pct, output int received);
   int            idle_cycles;
   logic          held;
   logic [DW-1:0] held_data;
   received    = 0;
   idle_cycles = 0;
   held        = 1'b0;
   held_data   = '0;
   while (received < WINDOW_WORDS) begin
      if (held) begin
         check_value("out_valid_o", 1, out_valid_o);
         check_value("out_data_o while stalled", held_data, out_data_o);
      end
      out_ready_i = (stall_pct == 0 || (next_random() % 100) >= stall_pct) ? 1'b1 : 1'b0;
      held        = out_valid_o && !out_ready_i;
      held_data   = out_data_o;
      if (out_valid_o && out_ready_i) begin
         check_value("out_data_o", frame_data[f][window_source(received)], out_data_o);
         received++;
         idle_cycles = 0;
      end else if (idle_cycles == TIMEOUT) begin
         report_timeout("no output word arrived before the frame was complete");
         out_ready_i = 1'b1;
         return;
      end else begin
         idle_cycles++;
      end
      @(negedge clk);
   end
   out_ready_i = 1'b1;
endtask

// words that show up after a complete frame
task automatic count_extra_words(input int cycles, output int extra);
   extra       = 0;
   out_ready_i = 1'b1;
   for (int i = 0; i < cycles; i++) begin
      if (out_valid_o) begin
         extra++;
      end
      @(negedge clk);
   end
endtask

`endif

// File: dv/swu_tb.sv
`default_nettype none

module swu_tb #(
   parameter int STRIDE = 1
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int SIMD         = swu_pkg::DEF_SIMD;
   localparam int IP_PRECISION = swu_pkg::DEF_IP_PRECISION;
   localparam int IFM_CHANNELS = swu_pkg::DEF_IFM_CHANNELS;
   localparam int IFM_DIM      = swu_pkg::DEF_IFM_DIM;
   localparam int KERNEL_DIM   = swu_pkg::DEF_KERNEL_DIM;
   localparam int EFF_CHANNELS = IFM_CHANNELS / SIMD;
   localparam int BUFFER_SIZE  = (KERNEL_DIM + STRIDE) * IFM_DIM * EFF_CHANNELS;
   localparam int DW           = SIMD * IP_PRECISION;
   localparam int FRAME_WORDS  = swu_pkg::frame_words(IFM_DIM, EFF_CHANNELS);
   localparam int OUT_DIM      = (IFM_DIM - KERNEL_DIM) / STRIDE + 1;
   localparam int WINDOW_WORDS = OUT_DIM * OUT_DIM * KERNEL_DIM * KERNEL_DIM * EFF_CHANNELS;
   localparam int TIMEOUT      = 2000;

   logic          clk;
   logic          resetn;
   logic [DW-1:0] in_data_i;
   logic          in_valid_i;
   logic          in_ready_o;
   logic [DW-1:0] out_data_o;
   logic          out_valid_o;
   logic          out_ready_i;

   logic [31:0]   rng_state;
   logic [DW-1:0] frame_data [2][FRAME_WORDS];
   int            error_count;
   int            check_count;

   swu_top #(
      .SIMD         (SIMD),
      .IP_PRECISION (IP_PRECISION),
      .IFM_CHANNELS (IFM_CHANNELS),
      .IFM_DIM      (IFM_DIM),
      .KERNEL_DIM   (KERNEL_DIM),
      .STRIDE       (STRIDE),
      .BUFFER_SIZE  (BUFFER_SIZE)
   ) dut_i (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   `include "swu_tb_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // reference model and stimulus data

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   // input word index feeding output word k of a frame
   function automatic int window_source(input int k);
      int ch;
      int kw;
      int kh;
      int ocol;
      int orow;
      ch   = k % EFF_CHANNELS;
      kw   = (k / EFF_CHANNELS) % KERNEL_DIM;
      kh   = (k / (EFF_CHANNELS * KERNEL_DIM)) % KERNEL_DIM;
      ocol = (k / (EFF_CHANNELS * KERNEL_DIM * KERNEL_DIM)) % OUT_DIM;
      orow = k / (EFF_CHANNELS * KERNEL_DIM * KERNEL_DIM * OUT_DIM);
      return ((orow * STRIDE + kh) * IFM_DIM + ocol * STRIDE + kw) * EFF_CHANNELS + ch;
   endfunction

   task automatic fill_frame(input int f);
      for (int i = 0; i < FRAME_WORDS; i++) begin
         frame_data[f][i] = DW'(next_random());
      end
   endtask

   ////////////////////////////////////////////////////////////
   // tests

   task automatic run_frame_test(input string name, input int gap_pct, input int stall_pct);
      int errors_before;
      int received;
      int extra;
      errors_before = error_count;
      apply_reset();
      fill_frame(0);
      fork
         drive_frame(0, gap_pct);
         collect_frame(0, stall_pct, received);
      join
      // nothing may follow the last window word of the frame
      count_extra_words(20, extra);
      check_value("output word count", WINDOW_WORDS, received + extra);
      report_test(name, errors_before);
   endtask

   task automatic run_two_frame_test();
      int errors_before;
      int received_a;
      int received_b;
      int extra;
      errors_before = error_count;
      apply_reset();
      fill_frame(0);
      fill_frame(1);
      fork
         begin
            drive_frame(0, 0);
            drive_frame(1, 0);
         end
         begin
            collect_frame(0, 0, received_a);
            collect_frame(1, 0, received_b);
         end
      join
      count_extra_words(20, extra);
      check_value("output word count", 2 * WINDOW_WORDS, received_a + received_b + extra);
      report_test("two frames", errors_before);
   endtask

   task automatic run_reset_state_test();
      int errors_before;
      int received;
      errors_before = error_count;
      apply_reset();
      for (int i = 0; i < 8; i++) begin
         check_value("out_valid_o", 0, out_valid_o);
         check_value("in_ready_o", 1, in_ready_o);
         @(negedge clk);
      end
      fill_frame(0);
      fork
         begin
            drive_frame(0, 0);
            // whole frame written, window still draining
            check_value("in_ready_o", 0, in_ready_o);
         end
         collect_frame(0, 0, received);
      join
      report_test("reset and full frame", errors_before);
   endtask

   initial begin
      resetn      = 1'b0;
      in_valid_i  = 1'b0;
      in_data_i   = '0;
      out_ready_i = 1'b0;
      rng_state   = 32'h123c;
      error_count = 0;
      check_count = 0;
      run_frame_test("full rate", 0, 0);
      run_frame_test("input gaps", 40, 0);
      run_frame_test("output stalls", 0, 40);
      run_two_frame_test();
      run_reset_state_test();
      $display("stride %0d: %0d checks, %0d errors", STRIDE, check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+dv
src/swu_pkg.sv
src/swu_buffer_ram.sv
src/swu_write_ctrl.sv
src/swu_window_ctrl.sv
src/swu_output_stage.sv
src/swu_top.sv
dv/swu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

for stride in 1 2; do
   mdir="obj_dir_stride${stride}"
   log="sim_stride${stride}.log"
   rm -rf "${mdir}"
   verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
      -f compile.f --top-module swu_tb -GSTRIDE=${stride} \
      --Mdir "${mdir}" -o swu_tb_sim
   "./${mdir}/swu_tb_sim" | tee "${log}"
   if ! grep -q "Simulation PASSED" "${log}"; then
      echo "stride ${stride}: simulation did not pass, see ${log}"
      exit 1
   fi
done
echo "all stride settings passed"
